//--- filelist.f
+incdir+common
common/exe_op_pkg.sv
common/exe_bus_pkg.sv
common/exe_operand_if.sv
rtl/exe_alu.sv
muldiv/radix2_divider.sv
muldiv/exe_muldiv.sv
rtl/exe_result_sel.sv
rtl/exe_stage.sv
dv/exe_properties.sv
dv/exe_checker.sv
dv/exe_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/exe_stage_tb.sv
`timescale 1ns/100ps

module exe_stage_tb;
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    typedef struct {
        ds_to_es_t   bus;
        int          stall;
        bit          flush;
        bit          has_exp;
        logic [31:0] exp;
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es_bus;
    logic        es_allowin;
    logic        ms_allowin;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic        out_es_valid;
    logic        wb_ex;
    entry_t      tbl[$];
    logic [31:0] seed;
    int          timeouts = 0;

    always #10 clk = ~clk;

    exe_stage uut (.*);
    exe_checker chk (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic add(input logic md, input logic [3:0] fn, input logic pc_sel,
                       input logic imm_sel, input logic [31:0] rj, input logic [31:0] rkd,
                       input logic [31:0] imm, input logic [1:0] st, input logic ld,
                       input int stall, input bit flush, input bit has,
                       input logic [31:0] exp);
        entry_t e;
        e.bus              = '0;
        e.bus.op.is_md     = md;
        e.bus.op.fn.alu    = alu_fn_e'(fn);
        e.bus.src1_is_pc   = pc_sel;
        e.bus.src2_is_imm  = imm_sel;
        e.bus.pc           = 32'h1000 + 32'(tbl.size() * 4);
        e.bus.rj_value     = rj;
        e.bus.rkd_value    = rkd;
        e.bus.imm          = imm;
        e.bus.gr_we        = (st == 2'd0);
        e.bus.dest         = 5'(tbl.size());
        e.bus.res_from_mem = ld;
        e.bus.st_size      = st_size_e'(st);
        e.bus.ld_op        = ld ? 5'd1 : 5'd0;
        e.stall            = stall;
        e.flush            = flush;
        e.has_exp          = has;
        e.exp              = exp;
        tbl.push_back(e);
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: time %0t timed out waiting for %s", $time, what);
        timeouts++;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_item(input entry_t e);
        int n;
        chk.note_expected(e.has_exp, e.exp);
        ms_allowin     = (e.stall == 0);
        ds_to_es_bus   = e.bus;
        ds_to_es_valid = 1'b1;
        n = 0;
        while (!es_allowin && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        if (!es_allowin)
            report_timeout("es_allowin");
        @(negedge clk);
        ds_to_es_valid = 1'b0;
        if (e.flush)
        begin
            repeat (5) @(negedge clk);
            wb_ex = 1'b1;
            @(negedge clk);
            wb_ex = 1'b0;
        end
        else
        begin
            repeat (e.stall) @(negedge clk);
            ms_allowin = 1'b1;
            n = 0;
            while (!es_to_ms_valid && n < 200)
            begin
                @(negedge clk);
                n++;
            end
            if (!es_to_ms_valid)
                report_timeout("es_to_ms_valid");
            @(negedge clk);
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  fn;
        seed           = 32'h7aae;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        ms_allowin     = 1'b1;
        wb_ex          = 1'b0;
        add(0, alu_sub,  1, 1, 0, 0, 32'd4, 0, 0, 0, 0, 1, 32'h0000_0ffc);
        add(0, alu_add,  0, 0, 5, 7, 0, 0, 0, 2, 0, 1, 32'd12);
        add(0, alu_slt,  0, 0, '1, 1, 0, 0, 0, 0, 0, 1, 32'd1);
        add(0, alu_sltu, 0, 0, '1, 1, 0, 0, 0, 1, 0, 1, 32'd0);
        add(0, alu_and,  0, 0, 32'hf0f0f0f0, 32'h0ff00ff0, 0, 0, 0, 0, 0, 1, 32'h00f000f0);
        add(0, alu_or,   0, 0, 32'hf0f0f0f0, 32'h0ff00ff0, 0, 0, 0, 0, 0, 1, 32'hfff0fff0);
        add(0, alu_nor,  0, 0, 32'hf0f0f0f0, 32'h0ff00ff0, 0, 0, 0, 0, 0, 1, 32'h000f000f);
        add(0, alu_xor,  0, 0, 32'hf0f0f0f0, 32'h0ff00ff0, 0, 0, 0, 3, 0, 1, 32'hff00ff00);
        add(0, alu_sll,  0, 0, 1, 32'h24, 0, 0, 0, 0, 0, 1, 32'h10);
        add(0, alu_srl,  0, 0, 32'h80000000, 4, 0, 0, 0, 0, 0, 1, 32'h08000000);
        add(0, alu_sra,  0, 1, 32'h80000000, 0, 4, 0, 0, 0, 0, 1, 32'hf8000000);
        add(0, alu_lui,  0, 1, 0, 0, 32'h12345000, 0, 0, 0, 0, 1, 32'h12345000);
        add(1, md_mul_w,   0, 0, 32'hfffffffe, 3, 0, 0, 0, 0, 0, 1, 32'hfffffffa);
        add(1, md_mulh_w,  0, 0, '1, '1, 0, 0, 0, 2, 0, 1, 32'h0);
        add(1, md_mulh_wu, 0, 0, '1, '1, 0, 0, 0, 0, 0, 1, 32'hfffffffe);
        add(1, md_div_w,   0, 0, -32'sd7, 2, 0, 0, 0, 3, 0, 1, 32'hfffffffd);
        add(1, md_mod_w,   0, 0, -32'sd7, 2, 0, 0, 0, 0, 0, 1, 32'hffffffff);
        add(1, md_div_wu,  0, 0, 100, 0, 0, 0, 0, 0, 0, 1, 32'hffffffff);
        add(1, md_mod_wu,  0, 0, 100, 0, 0, 0, 0, 0, 0, 1, 32'd100);
        add(1, md_div_w,   0, 0, 32'h80000000, '1, 0, 0, 0, 0, 0, 1, 32'h80000000);
        add(1, md_mod_w,   0, 0, 32'h80000000, '1, 0, 0, 0, 1, 0, 1, 32'h0);
        add(1, md_div_wu,  0, 0, 1000, 3, 0, 0, 0, 0, 1, 0, 32'h0);
        add(0, alu_add,  0, 1, 32'h2001, 32'h11223344, 2, 1, 0, 2, 0, 1, 32'h2003);
        add(0, alu_add,  0, 1, 32'h2001, 32'h11223344, 1, 2, 0, 0, 0, 1, 32'h2002);
        add(0, alu_add,  0, 1, 32'h2001, 32'h11223344, -32'sd1, 3, 0, 1, 0, 1, 32'h2000);
        add(0, alu_add,  0, 1, 32'h3000, 0, 0, 0, 1, 0, 0, 1, 32'h3000);
        for (int i = 0; i < 200; i++)
        begin
            r  = lcg_next();
            a  = lcg_next();
            b  = lcg_next();
            fn = r[0] ? 4'(r[7:4] % 4'd7) : 4'(r[7:4] % 4'd12);
            add(r[0], fn, 0, r[1], a, b, b ^ r, 0, 0, int'(r[9:8]), 0, 0, 32'h0);
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        foreach (tbl[i])
            run_item(tbl[i]);
        repeat (4) @(negedge clk);
        $display("errors: %0d check, %0d assertion, %0d timeout",
                 chk.error_count, uut.props.fail_count, timeouts);
        if (chk.error_count == 0 && uut.props.fail_count == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- dv/exe_checker.sv
`timescale 1ns/100ps

module exe_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   ds_to_es_valid,
    input exe_bus_pkg::ds_to_es_t ds_to_es_bus,
    input logic                   es_allowin,
    input logic                   ms_allowin,
    input logic                   es_to_ms_valid,
    input exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    input logic                   data_sram_en,
    input logic [3:0]             data_sram_we,
    input logic [31:0]            data_sram_addr,
    input logic [31:0]            data_sram_wdata,
    input logic                   out_es_valid,
    input logic                   wb_ex
);
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    typedef struct packed {
        es_to_ms_t   bus;
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } exp_t;

    exp_t        exp_q[$];
    logic [32:0] table_q[$];
    exp_t        e;
    logic [32:0] t;
    int          error_count = 0;

    // bit 32 marks an entry that carries a table value
    task automatic note_expected(input bit has, input logic [31:0] value);
        table_q.push_back({has, value});
    endtask

    task automatic check(input string name, input logic [31:0] expv, input logic [31:0] act);
        if (expv !== act)
        begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expv, act);
            error_count++;
        end
    endtask

    function automatic logic [31:0] model_result(input ds_to_es_t b);
        logic [31:0]     a;
        logic [31:0]     c;
        longint          sa;
        longint          sb;
        longint          p;
        longint unsigned up;
        a  = b.src1_is_pc ? b.pc : b.rj_value;
        c  = b.src2_is_imm ? b.imm : b.rkd_value;
        sa = $signed(a);
        sb = $signed(c);
        p  = sa * sb;
        up = {32'd0, a} * {32'd0, c};
        if (!b.op.is_md)
            case (b.op.fn.alu)
                alu_add:  return a + c;
                alu_sub:  return a - c;
                alu_slt:  return (sa < sb) ? 32'd1 : 32'd0;
                alu_sltu: return (a < c) ? 32'd1 : 32'd0;
                alu_and:  return a & c;
                alu_or:   return a | c;
                alu_nor:  return ~(a | c);
                alu_xor:  return a ^ c;
                alu_sll:  return a << c[4:0];
                alu_srl:  return a >> c[4:0];
                alu_sra:  return 32'(sa >>> c[4:0]);
                default:  return c;
            endcase
        case (b.op.fn.md)
            md_mul_w:   return p[31:0];
            md_mulh_w:  return p[63:32];
            md_mulh_wu: return up[63:32];
            // 64-bit division keeps min / -1 at min after truncation
            md_div_w:   return (c == 0) ? 32'hffff_ffff : 32'(sa / sb);
            md_mod_w:   return (c == 0) ? a : 32'(sa % sb);
            md_div_wu:  return (c == 0) ? 32'hffff_ffff : a / c;
            default:    return (c == 0) ? a : a % c;
        endcase
    endfunction

    function automatic exp_t expect_item(input ds_to_es_t b);
        exp_t x;
        x.bus.pc           = b.pc;
        x.bus.result       = model_result(b);
        x.bus.dest         = b.dest;
        x.bus.gr_we        = b.gr_we;
        x.bus.res_from_mem = b.res_from_mem;
        x.bus.ld_op        = b.ld_op;
        x.en               = b.res_from_mem || (b.st_size != st_none);
        x.addr             = x.bus.result;
        x.we               = 4'b0000;
        x.wdata            = b.rkd_value;
        if (b.st_size == st_byte)
        begin
            case (x.addr[1:0])
                2'd0:    x.we = 4'b0001;
                2'd1:    x.we = 4'b0010;
                2'd2:    x.we = 4'b0100;
                default: x.we = 4'b1000;
            endcase
            x.wdata = {4{b.rkd_value[7:0]}};
        end
        else if (b.st_size == st_half)
        begin
            x.we    = x.addr[1] ? 4'b1100 : 4'b0011;
            x.wdata = {2{b.rkd_value[15:0]}};
        end
        else if (b.st_size == st_word)
            x.we = 4'b1111;
        return x;
    endfunction

    always @(posedge clk)
    begin
        if (reset)
            exp_q.delete();
        else
        begin
            if (!out_es_valid && data_sram_en)
            begin
                $display("ERROR: time %0t data_sram_en high with an empty stage", $time);
                error_count++;
            end
            if (out_es_valid && exp_q.size() > 0)
                check("data_sram_en", {31'd0, exp_q[0].en}, {31'd0, data_sram_en});
            if (wb_ex)
            begin
                if (out_es_valid && exp_q.size() > 0)
                begin
                    e = exp_q.pop_front();
                    t = table_q.pop_front();
                end
            end
            else
            begin
                if (es_to_ms_valid && ms_allowin)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("ERROR: time %0t an item left with none expected", $time);
                        error_count++;
                    end
                    else
                    begin
                        e = exp_q.pop_front();
                        t = (table_q.size() > 0) ? table_q.pop_front() : 33'd0;
                        check("es_to_ms_bus.pc", e.bus.pc, es_to_ms_bus.pc);
                        check("es_to_ms_bus.result", e.bus.result, es_to_ms_bus.result);
                        check("es_to_ms_bus.dest", 32'(e.bus.dest), 32'(es_to_ms_bus.dest));
                        check("es_to_ms_bus.gr_we", 32'(e.bus.gr_we), 32'(es_to_ms_bus.gr_we));
                        check("es_to_ms_bus.res_from_mem", 32'(e.bus.res_from_mem),
                              32'(es_to_ms_bus.res_from_mem));
                        check("es_to_ms_bus.ld_op", 32'(e.bus.ld_op), 32'(es_to_ms_bus.ld_op));
                        check("data_sram_we", 32'(e.we), 32'(data_sram_we));
                        if (t[32])
                            check("table result", t[31:0], es_to_ms_bus.result);
                        if (e.en)
                            check("data_sram_addr", e.addr, data_sram_addr);
                        if (e.we != 4'b0000)
                            check("data_sram_wdata", e.wdata, data_sram_wdata);
                    end
                end
                if (ds_to_es_valid && es_allowin)
                    exp_q.push_back(expect_item(ds_to_es_bus));
            end
        end
    end

endmodule

//--- dv/exe_properties.sv
`timescale 1ns/100ps

module exe_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   ms_allowin,
    input logic                   es_allowin,
    input logic                   es_to_ms_valid,
    input exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    input logic                   out_es_valid,
    input logic                   wb_ex
);

    int fail_count = 0;

    // a stalled result stays put until memory takes it
    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin && !wb_ex |=> es_to_ms_valid && $stable(es_to_ms_bus))
        else
        begin
            $error("es_to_ms_bus changed while stalled");
            fail_count++;
        end

    no_allowin_on_stall: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |-> !es_allowin)
        else
        begin
            $error("es_allowin high while stalled");
            fail_count++;
        end

    valid_implies_busy: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid |-> out_es_valid)
        else
        begin
            $error("es_to_ms_valid without out_es_valid");
            fail_count++;
        end

    flush_empties_stage: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> !out_es_valid)
        else
        begin
            $error("stage still valid after wb_ex");
            fail_count++;
        end

endmodule

bind exe_stage exe_properties props (
    .clk            (clk),
    .reset          (reset),
    .ms_allowin     (ms_allowin),
    .es_allowin     (es_allowin),
    .es_to_ms_valid (es_to_ms_valid),
    .es_to_ms_bus   (es_to_ms_bus),
    .out_es_valid   (out_es_valid),
    .wb_ex          (wb_ex)
);

//--- rtl/exe_stage.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ds_to_es_valid,
    input  exe_bus_pkg::ds_to_es_t ds_to_es_bus,
    output logic                   es_allowin,
    input  logic                   ms_allowin,
    output logic                   es_to_ms_valid,
    output exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    output logic                   data_sram_en,
    output logic [3:0]             data_sram_we,
    output logic [`EXE_XLEN-1:0]   data_sram_addr,
    output logic [`EXE_XLEN-1:0]   data_sram_wdata,
    output logic                   out_es_valid,
    input  logic                   wb_ex
);
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    logic                 es_valid;
    ds_to_es_t            bus_q;
    logic                 issued;
    logic                 is_div;
    logic                 ready_go;
    logic [`EXE_XLEN-1:0] alu_result;
    logic [`EXE_XLEN-1:0] md_result;
    logic                 md_done;
    logic [3:0]           sram_we;
    logic                 sram_access;

    exe_operand_if ops ();

    always_ff @(posedge clk)
    begin
        if (reset || wb_ex)
            es_valid <= 1'b0;
        else if (es_allowin)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allowin)
            bus_q <= ds_to_es_bus;
    end

    // one divider start per item, cleared when the next item enters
    always_ff @(posedge clk)
    begin
        if (reset || wb_ex || (ds_to_es_valid && es_allowin))
            issued <= 1'b0;
        else if (ops.start)
            issued <= 1'b1;
    end

    assign is_div = bus_q.op.is_md &&
                    (bus_q.op.fn.md inside {md_div_w, md_mod_w, md_div_wu, md_mod_wu});

    assign ops.start = es_valid && is_div && !issued;
    assign ops.op    = bus_q.op;
    assign ops.src1  = bus_q.src1_is_pc ? bus_q.pc : bus_q.rj_value;
    assign ops.src2  = bus_q.src2_is_imm ? bus_q.imm : bus_q.rkd_value;
    assign ops.flush = wb_ex;

    // alu and multiply finish in the same cycle, divide waits on md_done
    assign ready_go       = !bus_q.op.is_md || md_done;
    assign es_allowin     = !es_valid || (ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && ready_go;

    exe_alu u_alu (
        .ops        (ops),
        .alu_result (alu_result)
    );

    exe_muldiv u_muldiv (
        .clk       (clk),
        .reset     (reset),
        .ops       (ops),
        .md_result (md_result),
        .md_done   (md_done)
    );

    exe_result_sel u_result_sel (
        .bus_q        (bus_q),
        .alu_result   (alu_result),
        .md_result    (md_result),
        .es_to_ms_bus (es_to_ms_bus),
        .sram_we      (sram_we),
        .sram_wdata   (data_sram_wdata),
        .sram_access  (sram_access)
    );

    assign data_sram_en   = es_valid && sram_access;
    assign data_sram_we   = {4{es_valid}} & sram_we;
    assign data_sram_addr = alu_result;

    assign out_es_valid = es_valid;

endmodule

//--- rtl/exe_result_sel.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_result_sel (
    input  exe_bus_pkg::ds_to_es_t bus_q,
    input  logic [`EXE_XLEN-1:0]   alu_result,
    input  logic [`EXE_XLEN-1:0]   md_result,
    output exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    output logic [3:0]             sram_we,
    output logic [`EXE_XLEN-1:0]   sram_wdata,
    output logic                   sram_access
);
    import exe_bus_pkg::*;

    logic [1:0] addr_lo;

    assign addr_lo = alu_result[1:0];

    assign es_to_ms_bus.pc           = bus_q.pc;
    assign es_to_ms_bus.result       = bus_q.op.is_md ? md_result : alu_result;
    assign es_to_ms_bus.dest         = bus_q.dest;
    assign es_to_ms_bus.gr_we        = bus_q.gr_we;
    assign es_to_ms_bus.res_from_mem = bus_q.res_from_mem;
    assign es_to_ms_bus.ld_op        = bus_q.ld_op;

    // narrow stores replicate, byte enables pick the lane
    always_comb
    begin
        case (bus_q.st_size)
            st_byte:
            begin
                sram_wdata = {4{bus_q.rkd_value[7:0]}};
                sram_we    = 4'b0001 << addr_lo;
            end
            st_half:
            begin
                sram_wdata = {2{bus_q.rkd_value[15:0]}};
                sram_we    = 4'b0011 << {addr_lo[1], 1'b0};
            end
            st_word:
            begin
                sram_wdata = bus_q.rkd_value;
                sram_we    = 4'b1111;
            end
            default:
            begin
                sram_wdata = bus_q.rkd_value;
                sram_we    = 4'b0000;
            end
        endcase
    end

    assign sram_access = bus_q.res_from_mem || (bus_q.st_size != st_none);

endmodule

//--- muldiv/exe_muldiv.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_muldiv (
    input  logic                 clk,
    input  logic                 reset,
    exe_operand_if.unit          ops,
    output logic [`EXE_XLEN-1:0] md_result,
    output logic                 md_done
);
    import exe_op_pkg::*;

    md_fn_e                        fn;
    logic                          is_div;
    logic                          is_signed_div;
    logic                          sign_ext;
    logic signed [`EXE_XLEN:0]     mul_a;
    logic signed [`EXE_XLEN:0]     mul_b;
    logic signed [2*`EXE_XLEN+1:0] product;
    logic [`EXE_XLEN-1:0]          quotient;
    logic [`EXE_XLEN-1:0]          remainder;
    logic                          div_done;
    logic                          done_q;

    assign fn            = ops.op.fn.md;
    assign is_div        = fn inside {md_div_w, md_mod_w, md_div_wu, md_mod_wu};
    assign is_signed_div = (fn == md_div_w) || (fn == md_mod_w);

    // 33-bit operands cover both signed and unsigned high halves
    assign sign_ext = (fn == md_mulh_w);
    assign mul_a    = {sign_ext & ops.src1[`EXE_XLEN-1], ops.src1};
    assign mul_b    = {sign_ext & ops.src2[`EXE_XLEN-1], ops.src2};
    assign product  = mul_a * mul_b;

    radix2_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (ops.start),
        .flush     (ops.flush),
        .is_signed (is_signed_div),
        .dividend  (ops.src1),
        .divisor   (ops.src2),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    // divider only pulses done, keep it until the item moves on
    always_ff @(posedge clk)
    begin
        if (reset || ops.flush || ops.start)
            done_q <= 1'b0;
        else if (div_done)
            done_q <= 1'b1;
    end

    // stale done from an earlier divide must not leak into a start cycle
    assign md_done = is_div ? ((div_done | done_q) & ~ops.start) : 1'b1;

    always_comb
    begin
        case (fn)
            md_mul_w:               md_result = product[`EXE_XLEN-1:0];
            md_mulh_w, md_mulh_wu:  md_result = product[2*`EXE_XLEN-1:`EXE_XLEN];
            md_div_w, md_div_wu:    md_result = quotient;
            md_mod_w, md_mod_wu:    md_result = remainder;
            default:                md_result = '0;
        endcase
    end

endmodule

//--- muldiv/radix2_divider.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module radix2_divider (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 flush,
    input  logic                 is_signed,
    input  logic [`EXE_XLEN-1:0] dividend,
    input  logic [`EXE_XLEN-1:0] divisor,
    output logic [`EXE_XLEN-1:0] quotient,
    output logic [`EXE_XLEN-1:0] remainder,
    output logic                 done
);
    localparam int CNT_W = $clog2(`EXE_DIV_STEPS + 1);

    logic                 busy;
    logic [CNT_W-1:0]     count;
    logic [`EXE_XLEN-1:0] rem_q;
    logic [`EXE_XLEN-1:0] quo_q;
    logic [`EXE_XLEN-1:0] dvs_q;
    logic                 neg_q;
    logic                 neg_r;
    logic                 div_zero;
    logic [`EXE_XLEN-1:0] dvd_mag;
    logic [`EXE_XLEN-1:0] dvs_mag;
    logic [`EXE_XLEN:0]   shifted;
    logic [`EXE_XLEN+1:0] diff;

    assign dvd_mag = (is_signed && dividend[`EXE_XLEN-1]) ? -dividend : dividend;
    assign dvs_mag = (is_signed && divisor[`EXE_XLEN-1]) ? -divisor : divisor;

    // bring down next dividend bit, borrow says whether it fits
    assign shifted = {rem_q, quo_q[`EXE_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end
        else if (start)
        begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= CNT_W'(`EXE_DIV_STEPS);
        end
        else if (busy)
        begin
            count <= count - 1'b1;
            if (count == CNT_W'(1))
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
        else
            done <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem_q    <= '0;
            quo_q    <= dvd_mag;
            dvs_q    <= dvs_mag;
            neg_q    <= is_signed & (dividend[`EXE_XLEN-1] ^ divisor[`EXE_XLEN-1]);
            neg_r    <= is_signed & dividend[`EXE_XLEN-1];
            div_zero <= (divisor == '0);
        end
        else if (busy)
        begin
            if (!diff[`EXE_XLEN+1])
            begin
                rem_q <= diff[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b1};
            end
            else
            begin
                rem_q <= shifted[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b0};
            end
        end
    end

    // min / -1 wraps back to min on negation, which is the wanted result
    assign quotient  = div_zero ? '1 : (neg_q ? -quo_q : quo_q);
    assign remainder = neg_r ? -rem_q : rem_q;

endmodule

//--- rtl/exe_alu.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_alu (
    exe_operand_if.unit          ops,
    output logic [`EXE_XLEN-1:0] alu_result
);
    import exe_op_pkg::*;

    alu_fn_e    fn;
    logic [4:0] shamt;

    assign fn    = ops.op.fn.alu;
    assign shamt = ops.src2[4:0];

    always_comb
    begin
        case (fn)
            alu_add:
                alu_result = ops.src1 + ops.src2;
            alu_sub:
                alu_result = ops.src1 - ops.src2;
            alu_slt:
                alu_result = {31'd0, $signed(ops.src1) < $signed(ops.src2)};
            alu_sltu:
                alu_result = {31'd0, ops.src1 < ops.src2};
            alu_and:
                alu_result = ops.src1 & ops.src2;
            alu_or:
                alu_result = ops.src1 | ops.src2;
            alu_nor:
                alu_result = ~(ops.src1 | ops.src2);
            alu_xor:
                alu_result = ops.src1 ^ ops.src2;
            alu_sll:
                alu_result = ops.src1 << shamt;
            alu_srl:
                alu_result = ops.src1 >> shamt;
            alu_sra:
                alu_result = $signed(ops.src1) >>> shamt;
            // immediate already shifted into place by decode
            alu_lui:
                alu_result = ops.src2;
            default:
                alu_result = '0;
        endcase
    end

endmodule

//--- common/exe_operand_if.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

interface exe_operand_if;
    import exe_op_pkg::*;

    logic                 start;
    exe_op_t              op;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic                 flush;

    modport stage (
        output start, op, src1, src2, flush
    );

    // ALU and multiply/divide unit both listen
    modport unit (
        input start, op, src1, src2, flush
    );

endinterface

//--- common/exe_bus_pkg.sv
`include "exe_defines.svh"

package exe_bus_pkg;

    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_byte = 2'd1,
        st_half = 2'd2,
        st_word = 2'd3
    } st_size_e;

    typedef struct packed {
        exe_op_pkg::exe_op_t   op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [`EXE_XLEN-1:0]  pc;
        logic [`EXE_XLEN-1:0]  rj_value;
        logic [`EXE_XLEN-1:0]  rkd_value;
        logic [`EXE_XLEN-1:0]  imm;
        logic                  gr_we;
        logic [`EXE_REG_W-1:0] dest;
        logic                  res_from_mem;
        st_size_e              st_size;
        logic [4:0]            ld_op;
    } ds_to_es_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]  pc;
        logic [`EXE_XLEN-1:0]  result;
        logic [`EXE_REG_W-1:0] dest;
        logic                  gr_we;
        logic                  res_from_mem;
        logic [4:0]            ld_op;
    } es_to_ms_t;

endpackage

//--- common/exe_op_pkg.sv
package exe_op_pkg;

    // integer ALU functions
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_fn_e;

    // multiply and divide functions
    typedef enum logic [3:0] {
        md_mul_w   = 4'd0,
        md_mulh_w  = 4'd1,
        md_mulh_wu = 4'd2,
        md_div_w   = 4'd3,
        md_mod_w   = 4'd4,
        md_div_wu  = 4'd5,
        md_mod_wu  = 4'd6
    } md_fn_e;

    // same four bits, read by whichever unit is_md selects
    typedef union packed {
        alu_fn_e alu;
        md_fn_e  md;
    } exe_fn_u;

    typedef struct packed {
        logic    is_md;
        exe_fn_u fn;
    } exe_op_t;

endpackage

//--- common/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// datapath width fixed by the ISA
`define EXE_XLEN 32

// register file index width
`define EXE_REG_W 5

// one quotient bit per divider iteration
`define EXE_DIV_STEPS 32

`endif
